//--- Makefile
VERILATOR ?= verilator
TOP       ?= fifo_switch_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) fifo_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Verification failed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+.
fifo_pkg.sv
dual_port_memory.sv
fifo.sv
rr_arbiter.sv
lane_router.sv
fifo_switch.sv
tb_clock_gen.sv
fifo_switch_tb.sv

//--- dual_port_memory.sv
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module dual_port_memory #(
    parameter int DEPTH = `FIFO_DEPTH,
    parameter int AW    = `FIFO_AW
) (
    input  logic            clk,
    input  logic            write_en,
    input  logic [AW-1:0]   write_addr,
    input  fifo_pkg::word_t write_data,
    input  logic [AW-1:0]   read_addr,
    output fifo_pkg::word_t read_data
);

    fifo_pkg::word_t mem [DEPTH];

    // Write port, one word per clock
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Read port is combinational so the head word shows without a pop
    assign read_data = mem[read_addr];

endmodule

//--- fifo.sv
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifo #(
    parameter int DEPTH = `FIFO_DEPTH,
    parameter int AW    = `FIFO_AW
) (
    input  logic            clk,
    input  logic            reset_L,
    input  logic            push,
    input  logic            pop,
    input  fifo_pkg::word_t data_in,
    output fifo_pkg::word_t data_out,
    output logic            empty,
    output logic            almost_empty,
    output logic            almost_full,
    output logic            full,
    output logic            pause,
    output logic            error
);

    localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);
    localparam logic [AW:0] AE_CNT   = (AW+1)'(`FIFO_AE_LVL);
    localparam logic [AW:0] AF_CNT   = (AW+1)'(`FIFO_AF_LVL);

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;       // Words held
    logic [AW:0]   count_next;
    logic          push_ok;
    logic          pop_ok;

    dual_port_memory #(
        .DEPTH (DEPTH),
        .AW    (AW)
    ) mem_i (
        .clk        (clk),
        .write_en   (push_ok),
        .write_addr (wr_ptr),
        .write_data (data_in),
        .read_addr  (rd_ptr),
        .read_data  (data_out)
    );

    assign pop_ok  = pop && (count != '0);
    // A full FIFO still takes a word when one leaves in the same cycle
    assign push_ok = push && ((count != FULL_CNT) || pop_ok);

    always_comb begin
        case ({push_ok, pop_ok})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;  // Idle, or push and pop together
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
        end
    end

    // Status flags follow the count of the same edge
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            empty        <= 1'b1;
            almost_empty <= 1'b0;
            almost_full  <= 1'b0;
            full         <= 1'b0;
            error        <= 1'b0;
        end else begin
            empty        <= (count_next == '0);
            almost_empty <= (count_next == AE_CNT);
            almost_full  <= (count_next >= AF_CNT);
            full         <= (count_next == FULL_CNT);
            // Refused push or pop from an empty FIFO
            error        <= (push && !push_ok) || (pop && !pop_ok);
        end
    end

    assign pause = almost_full;  // Back-pressure level toward the arbiter

endmodule

//--- fifo_cfg.svh
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// Lanes on each side of the switch
`define FIFO_LANES 4

// Word width, top two bits select the output lane
`define FIFO_WORD_W 6

// Entries per FIFO and the matching pointer width
`define FIFO_DEPTH 4
`define FIFO_AW 2

// Fixed thresholds on the occupancy count
`define FIFO_AE_LVL 1  // Almost empty at exactly this count
`define FIFO_AF_LVL 3  // Almost full and pause at this count or more

`endif

//--- fifo_pkg.sv
`include "fifo_cfg.svh"

package fifo_pkg;

    typedef logic [`FIFO_WORD_W-1:0] word_t;

    // Output lane number, taken from the top bits of a word
    typedef logic [$clog2(`FIFO_LANES)-1:0] dest_t;

    typedef logic [`FIFO_WORD_W-$bits(dest_t)-1:0] payload_t;  // Bits below the destination

    typedef logic [`FIFO_LANES-1:0] lane_mask_t;  // One bit per lane

    typedef logic [`FIFO_AW:0] count_t;  // 0 to depth

    // Arbiter pointer, the lane that is looked at first
    typedef enum logic [1:0] {LANE0, LANE1, LANE2, LANE3} arb_state_t;

endpackage

//--- fifo_switch.sv
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifo_switch (
    input  logic                              clk,
    input  logic                              reset_L,
    input  fifo_pkg::lane_mask_t              push_in,
    input  fifo_pkg::word_t [`FIFO_LANES-1:0] data_in,
    input  fifo_pkg::lane_mask_t              pop_out,
    output fifo_pkg::word_t [`FIFO_LANES-1:0] data_out,
    output fifo_pkg::lane_mask_t              in_full,
    output fifo_pkg::lane_mask_t              in_error,
    output fifo_pkg::lane_mask_t              out_empty,
    output fifo_pkg::lane_mask_t              out_almost_empty,
    output fifo_pkg::lane_mask_t              out_almost_full,
    output fifo_pkg::lane_mask_t              out_full,
    output fifo_pkg::lane_mask_t              out_error
);

    fifo_pkg::word_t [`FIFO_LANES-1:0] head_word;  // Input FIFO heads
    fifo_pkg::lane_mask_t              in_empty;
    fifo_pkg::lane_mask_t              out_pause;
    fifo_pkg::lane_mask_t              grant;      // Doubles as input pop
    fifo_pkg::word_t                   grant_word;
    logic                              grant_valid;
    fifo_pkg::lane_mask_t              route_push;
    fifo_pkg::word_t                   route_word;

    for (genvar k = 0; k < `FIFO_LANES; k++) begin : g_in
        fifo in_fifo_i (
            .clk          (clk),
            .reset_L      (reset_L),
            .push         (push_in[k]),
            .pop          (grant[k]),
            .data_in      (data_in[k]),
            .data_out     (head_word[k]),
            .empty        (in_empty[k]),
            .almost_empty (),
            .almost_full  (),
            .full         (in_full[k]),
            .pause        (),
            .error        (in_error[k])
        );
    end

    rr_arbiter arb_i (
        .clk         (clk),
        .reset_L     (reset_L),
        .head_word   (head_word),
        .in_empty    (in_empty),
        .out_pause   (out_pause),
        .grant       (grant),
        .grant_word  (grant_word),
        .grant_valid (grant_valid)
    );

    lane_router router_i (
        .clk         (clk),
        .reset_L     (reset_L),
        .grant_word  (grant_word),
        .grant_valid (grant_valid),
        .out_push    (route_push),
        .out_word    (route_word)
    );

    // All outputs see the same word, only one gets the push
    for (genvar j = 0; j < `FIFO_LANES; j++) begin : g_out
        fifo out_fifo_i (
            .clk          (clk),
            .reset_L      (reset_L),
            .push         (route_push[j]),
            .pop          (pop_out[j]),
            .data_in      (route_word),
            .data_out     (data_out[j]),
            .empty        (out_empty[j]),
            .almost_empty (out_almost_empty[j]),
            .almost_full  (out_almost_full[j]),
            .full         (out_full[j]),
            .pause        (out_pause[j]),
            .error        (out_error[j])
        );
    end

endmodule

//--- fifo_switch_tb.sv
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifo_switch_tb;

    localparam int LANES = `FIFO_LANES;
    localparam int WAIT_MAX = 200;

    logic                         clk;
    logic                         gen_reset_L;
    logic                         tb_reset_L;
    logic                         reset_L;
    fifo_pkg::lane_mask_t         push_in;
    fifo_pkg::word_t [LANES-1:0]  data_in;
    fifo_pkg::lane_mask_t         pop_out;
    fifo_pkg::word_t [LANES-1:0]  data_out;
    fifo_pkg::lane_mask_t         in_full;
    fifo_pkg::lane_mask_t         in_error;
    fifo_pkg::lane_mask_t         out_empty;
    fifo_pkg::lane_mask_t         out_almost_empty;
    fifo_pkg::lane_mask_t         out_almost_full;
    fifo_pkg::lane_mask_t         out_full;
    fifo_pkg::lane_mask_t         out_error;

    fifo_pkg::word_t      sb_q [LANES][LANES][$];  // [source lane][output]
    fifo_pkg::word_t      arrival_log [$];         // Words popped from output 0
    fifo_pkg::lane_mask_t out_err_exp;
    fifo_pkg::lane_mask_t in_err_exp;
    logic [31:0]          lfsr;
    int                   errors;
    int                   tests_passed;
    int                   tests_failed;

    assign reset_L = gen_reset_L && tb_reset_L;

    tb_clock_gen clk_gen_i (
        .clk     (clk),
        .reset_L (gen_reset_L)
    );

    fifo_switch dut_i (
        .clk              (clk),
        .reset_L          (reset_L),
        .push_in          (push_in),
        .data_in          (data_in),
        .pop_out          (pop_out),
        .data_out         (data_out),
        .in_full          (in_full),
        .in_error         (in_error),
        .out_empty        (out_empty),
        .out_almost_empty (out_almost_empty),
        .out_almost_full  (out_almost_full),
        .out_full         (out_full),
        .out_error        (out_error)
    );

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Destination, source lane and a sequence number packed into one word
    function automatic fifo_pkg::word_t make_word(input int dest, input int lane, input int seq);
        return {2'(dest), 2'(lane), 2'(seq)};
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int k = 0; k < LANES; k++) begin
            for (int j = 0; j < LANES; j++) n += sb_q[k][j].size();
        end
        return n;
    endfunction

    task automatic report_error(input string msg);
        $display("error @ %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic timeout_fail(input string msg);
        $display("Timeout while waiting: %s", msg);
        $display("Verification failed");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        tb_reset_L = 1'b0;
        push_in    = '0;
        pop_out    = '0;
        repeat (8) @(negedge clk);
        for (int k = 0; k < LANES; k++) begin
            for (int j = 0; j < LANES; j++) sb_q[k][j].delete();
        end
        arrival_log.delete();
        tb_reset_L = 1'b1;
    endtask

    // Pops every non-empty output until the model holds nothing
    task automatic drain_outputs();
        int n;
        for (n = 0; n < WAIT_MAX; n++) begin
            @(negedge clk);
            if (pending() == 0 && out_empty == '1) break;
            pop_out = ~out_empty;
        end
        pop_out = '0;
        if (n == WAIT_MAX) timeout_fail("outputs never drained");
    endtask

    // Scoreboard and flag checks on every active edge
    always @(posedge clk) begin : monitor
        int src;
        fifo_pkg::word_t exp_w;
        if (!reset_L) begin
            out_err_exp <= '0;
            in_err_exp  <= '0;
        end else begin
            for (int j = 0; j < LANES; j++) begin
                assert (out_error[j] == out_err_exp[j])
                    else report_error($sformatf("out_error[%0d] is %b", j, out_error[j]));
                assert (!(out_empty[j] && (out_almost_empty[j] || out_almost_full[j])))
                    else report_error($sformatf("output %0d empty with almost flag", j));
                assert (!out_full[j] || out_almost_full[j])
                    else report_error($sformatf("output %0d full without almost_full", j));
                assert (!(out_almost_empty[j] && out_almost_full[j]))
                    else report_error($sformatf("output %0d almost empty and full", j));
                if (pop_out[j] && !out_empty[j]) begin
                    src = int'(data_out[j][3:2]);
                    if (j == 0) arrival_log.push_back(data_out[j]);
                    assert (int'(data_out[j][5:4]) == j)
                        else report_error($sformatf("output %0d got %h", j, data_out[j]));
                    if (sb_q[src][j].size() == 0) begin
                        report_error($sformatf("extra word %h on output %0d", data_out[j], j));
                    end else begin
                        exp_w = sb_q[src][j].pop_front();
                        assert (data_out[j] == exp_w)
                            else report_error($sformatf("output %0d word %h, expected %h",
                                                        j, data_out[j], exp_w));
                    end
                end
            end
            for (int k = 0; k < LANES; k++) begin
                assert (in_error[k] == in_err_exp[k])
                    else report_error($sformatf("in_error[%0d] is %b", k, in_error[k]));
                if (push_in[k] && !in_full[k]) begin
                    sb_q[k][int'(data_in[k][5:4])].push_back(data_in[k]);
                end
            end
            out_err_exp <= pop_out & out_empty;  // Pop of an empty FIFO
            in_err_exp  <= push_in & in_full;    // No grant reaches a full lane here
        end
    end

    initial begin
        int n;
        int e0;
        logic [4:0] seen;
        lfsr         = 32'h25de_0dd5;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        tb_reset_L   = 1'b1;
        push_in      = '0;
        pop_out      = '0;
        data_in      = '0;
        for (n = 0; n < WAIT_MAX; n++) begin
            @(negedge clk);
            if (reset_L) break;
        end
        if (n == WAIT_MAX) timeout_fail("reset never released");
        assert (out_empty == '1 && out_full == '0 && in_full == '0 &&
                out_almost_full == '0 && out_almost_empty == '0)
            else report_error("flags wrong after reset");

        // Test 1 sends one word from lane 0 to output 2
        e0 = errors;
        push_in[0] = 1'b1;
        data_in[0] = make_word(2, 0, 1);
        @(negedge clk);
        push_in = '0;
        for (n = 0; n < WAIT_MAX; n++) begin
            @(negedge clk);
            if (!out_empty[2]) break;
        end
        if (n == WAIT_MAX) timeout_fail("word never reached output 2");
        assert (data_out[2] == make_word(2, 0, 1))
            else report_error($sformatf("output 2 shows %h", data_out[2]));
        assert (out_empty == 4'b1011) else report_error("another output left empty");
        drain_outputs();
        finish_test("single_word", e0);

        // Test 2 walks the flags of output 1
        e0 = errors;
        seen = '0;
        for (n = 0; n < 40; n++) begin
            @(negedge clk);
            if (out_empty[1]) seen[0] = 1'b1;
            else if (out_almost_empty[1]) seen[1] = 1'b1;
            else if (out_full[1]) seen[4] = 1'b1;
            else if (out_almost_full[1]) seen[3] = 1'b1;
            else seen[2] = 1'b1;
            if (out_full[1]) break;
            if (n < 4) begin
                push_in[0] = 1'b1;
                data_in[0] = make_word(1, 0, n);
            end else begin
                push_in = '0;
            end
        end
        push_in = '0;
        if (!out_full[1]) timeout_fail("output 1 never became full");
        assert (seen == 5'b11111) else report_error($sformatf("flag states seen %b", seen));
        for (n = 0; n < 5; n++) begin
            @(negedge clk);
            pop_out[1] = 1'b1;  // Fifth pop hits an empty FIFO
        end
        @(negedge clk);
        pop_out = '0;
        assert (out_error[1] && out_empty[1]) else report_error("no error pulse on empty pop");
        @(negedge clk);
        assert (!out_error[1]) else report_error("out_error[1] longer than one cycle");
        finish_test("flag_walk", e0);

        // Test 3 backs up lane 3 behind a full output 3
        e0 = errors;
        for (n = 0; n < 4; n++) begin
            @(negedge clk);
            push_in[0] = 1'b1;
            data_in[0] = make_word(3, 0, n);
        end
        @(negedge clk);
        push_in = '0;
        for (n = 0; n < WAIT_MAX; n++) begin
            @(negedge clk);
            if (out_full[3]) break;
        end
        if (n == WAIT_MAX) timeout_fail("output 3 never became full");
        for (n = 0; n < 5; n++) begin
            if (n == 4) assert (in_full[3]) else report_error("in_full[3] low after 4 pushes");
            push_in[3] = 1'b1;
            data_in[3] = make_word(3, 3, n);
            @(negedge clk);
        end
        push_in = '0;
        assert (in_error[3]) else report_error("refused push gave no in_error");
        @(negedge clk);
        assert (!in_error[3]) else report_error("in_error[3] longer than one cycle");
        drain_outputs();
        assert (in_full == '0) else report_error("in_full stuck after drain");
        finish_test("back_pressure", e0);

        // Test 4 checks the round-robin order into output 0
        e0 = errors;
        reset_dut();
        for (n = 0; n < 2; n++) begin
            @(negedge clk);
            push_in = '1;
            for (int k = 0; k < LANES; k++) data_in[k] = make_word(0, k, n);
        end
        @(negedge clk);
        push_in = '0;
        drain_outputs();
        assert (arrival_log.size() == 8)
            else report_error($sformatf("%0d words reached output 0", arrival_log.size()));
        for (int i = 0; i < arrival_log.size(); i++) begin
            assert (arrival_log[i] == make_word(0, i % 4, i / 4))
                else report_error($sformatf("arrival %0d is %h", i, arrival_log[i]));
        end
        finish_test("fairness", e0);

        // Test 5 runs random traffic with random pops
        e0 = errors;
        for (n = 0; n < 400; n++) begin
            @(negedge clk);
            for (int k = 0; k < LANES; k++) begin
                push_in[k] = !in_full[k] && (rand_bits(1) != '0);
                data_in[k] = make_word(int'(rand_bits(2)), k, int'(rand_bits(2)));
            end
            pop_out = fifo_pkg::lane_mask_t'(rand_bits(4));
        end
        @(negedge clk);
        push_in = '0;
        pop_out = '0;
        drain_outputs();
        finish_test("random_traffic", e0);

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Hard limit on the whole run
    initial begin
        #2ms;
        timeout_fail("simulation time limit");
    end

endmodule

//--- lane_router.sv
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module lane_router (
    input  logic                 clk,
    input  logic                 reset_L,
    input  fifo_pkg::word_t      grant_word,
    input  logic                 grant_valid,
    output fifo_pkg::lane_mask_t out_push,
    output fifo_pkg::word_t      out_word
);

    localparam int DEST_W = $bits(fifo_pkg::dest_t);
    localparam int PAY_W  = $bits(fifo_pkg::payload_t);

    logic                 valid_q;    // Stage holds a word
    fifo_pkg::dest_t      dest_q;
    fifo_pkg::payload_t   payload_q;

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= grant_valid;
        end
    end

    // Word itself is only loaded on a grant
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            dest_q    <= grant_word[`FIFO_WORD_W-1 -: DEST_W];
            payload_q <= grant_word[PAY_W-1:0];
        end
    end

    // Destination bits travel with the word into the output FIFO
    assign out_word = {dest_q, payload_q};

    // One-hot push toward the selected output
    always_comb begin
        out_push = '0;
        if (valid_q) begin
            out_push[dest_q] = 1'b1;
        end
    end

endmodule

//--- rr_arbiter.sv
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module rr_arbiter (
    input  logic                              clk,
    input  logic                              reset_L,
    input  fifo_pkg::word_t [`FIFO_LANES-1:0] head_word,
    input  fifo_pkg::lane_mask_t              in_empty,
    input  fifo_pkg::lane_mask_t              out_pause,
    output fifo_pkg::lane_mask_t              grant,
    output fifo_pkg::word_t                   grant_word,
    output logic                              grant_valid
);

    localparam int DEST_W = $bits(fifo_pkg::dest_t);

    fifo_pkg::arb_state_t start_q;     // Lane scanned first
    fifo_pkg::arb_state_t start_next;
    fifo_pkg::dest_t      head_dest [`FIFO_LANES];
    fifo_pkg::lane_mask_t eligible;

    // A lane may go when it holds a word and its target output has room
    always_comb begin
        for (int k = 0; k < `FIFO_LANES; k++) begin
            head_dest[k] = head_word[k][`FIFO_WORD_W-1 -: DEST_W];
            eligible[k]  = !in_empty[k] && !out_pause[head_dest[k]];
        end
    end

    // Scan from the pointer, first eligible lane wins
    always_comb begin
        fifo_pkg::dest_t idx;
        logic            found;

        grant      = '0;
        grant_word = '0;
        found      = 1'b0;
        start_next = start_q;
        for (int i = 0; i < `FIFO_LANES; i++) begin
            idx = fifo_pkg::dest_t'(start_q) + fifo_pkg::dest_t'(i);  // Wraps at lane 3
            if (!found && eligible[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                grant_word = head_word[idx];
                start_next = fifo_pkg::arb_state_t'(idx + 2'd1);  // Next scan starts past the winner
            end
        end
        grant_valid = found;
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            start_q <= fifo_pkg::LANE0;
        end else begin
            start_q <= start_next;
        end
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic reset_L
);

    initial begin
        clk     = 1'b0;
        reset_L = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_L = 1'b1;  // Released away from the active edge
    end

    always #4 clk = ~clk;  // 8 ns period

endmodule
